// File: verilog.f
logic/csr_pkg.sv
logic/csr_trap_regs.sv
logic/csr_counters.sv
logic/irq_pending.sv
logic/trap_request.sv
logic/csr_read_decode.sv
logic/csr_unit.sv
bench/csr_unit_checker.sv
bench/tb_csr_unit.sv

// File: run.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f verilog.f --top-module tb_csr_unit -o tb_csr_unit
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_csr_unit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qF '** PASS **'; then
	exit 0
fi
exit 1

// File: bench/tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit;

	logic                clk = 1'b0;
	logic                rst_n;
	csr_pkg::csr_addr_t  addr;
	logic [31:0]         wdata;
	logic                wen, ren;
	csr_pkg::csr_wtype_e wtype;
	logic [31:0]         rdata;
	logic                illegal;
	logic [31:0]         trap_addr;
	logic                trap_is_irq, trap_enter_vld, trap_enter_rdy;
	logic [31:0]         mepc_in;
	csr_pkg::except_e    except;
	logic                delay_irq_entry;
	logic [7:0]          irq;
	logic                irq_software, irq_timer, instr_ret;
	int                  check_errors;
	int                  timeouts = 0;
	logic [15:0]         lfsr = 16'd26;     // Seed
	logic [31:0]         pattern;

	always #5 clk = ~clk;                   // 10 ns period

	csr_unit u_csr_unit (.*);

	csr_unit_checker u_checker (.*, .errors(check_errors));

	// ------------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------------
	// 16 bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_word(output logic [31:0] w);
		for (int i = 0; i < 32; i++) begin
			lfsr = lfsr_step(lfsr);         // One step per bit
			w[i] = lfsr[0];
		end
	endtask

	// One access cycle that the checker samples at the following edge
	task automatic csr_access(input csr_pkg::csr_addr_t a, input logic [31:0] d,
		input csr_pkg::csr_wtype_e t, input logic w, input logic r);
		@(posedge clk);
		addr  <= a;
		wdata <= d;
		wtype <= t;
		wen   <= w;
		ren   <= r;
	endtask

	task automatic csr_write(input csr_pkg::csr_addr_t a, input logic [31:0] d,
		input csr_pkg::csr_wtype_e t);
		csr_access(a, d, t, 1'b1, 1'b0);
	endtask

	task automatic csr_read(input csr_pkg::csr_addr_t a);
		csr_access(a, '0, csr_pkg::wtype_write, 1'b0, 1'b1);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			wen       <= 1'b0;
			ren       <= 1'b0;
			instr_ret <= 1'b0;
		end
	endtask

	task automatic raise_except(input csr_pkg::except_e e, input logic [31:0] pc);
		@(posedge clk);
		wen     <= 1'b0;
		ren     <= 1'b0;
		mepc_in <= pc;
		except  <= e;
	endtask

	// Poll on the falling edge where the request has settled
	task automatic wait_trap();
		int n;
		n = 0;
		@(negedge clk);
		while (!trap_enter_vld && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (!trap_enter_vld) begin
			timeouts++;
			$display("timeout at %0t, trap_enter_vld never rose", $time);
		end
	endtask

	// rdy for one cycle and then drop any exception
	task automatic accept_trap();
		@(posedge clk);
		wen            <= 1'b0;
		ren            <= 1'b0;
		trap_enter_rdy <= 1'b1;
		@(posedge clk);
		trap_enter_rdy <= 1'b0;
		except         <= csr_pkg::except_none;
	endtask

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------
	initial begin
		rst_n           = 1'b0;
		addr            = '0;
		wdata           = '0;
		wen             = 1'b0;
		ren             = 1'b0;
		wtype           = csr_pkg::wtype_write;
		trap_enter_rdy  = 1'b0;
		mepc_in         = '0;
		except          = csr_pkg::except_none;
		delay_irq_entry = 1'b0;
		irq             = '0;
		irq_software    = 1'b0;
		irq_timer       = 1'b0;
		instr_ret       = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// mscratch write, set, clear and mepc alignment
		random_word(pattern);
		csr_write(csr_pkg::MSCRATCH, pattern, csr_pkg::wtype_write);
		csr_read(csr_pkg::MSCRATCH);
		random_word(pattern);
		csr_write(csr_pkg::MSCRATCH, pattern, csr_pkg::wtype_set);
		csr_read(csr_pkg::MSCRATCH);
		random_word(pattern);
		csr_write(csr_pkg::MSCRATCH, pattern, csr_pkg::wtype_clear);
		csr_read(csr_pkg::MSCRATCH);
		csr_write(csr_pkg::MEPC, 32'hffff_ffff, csr_pkg::wtype_write);
		csr_read(csr_pkg::MEPC);

		// Illegal accesses
		csr_read(12'h7c0);                  // Unmapped
		csr_write(csr_pkg::MHARTID, 32'h1, csr_pkg::wtype_write);
		csr_write(csr_pkg::MLEI, 32'h1, csr_pkg::wtype_write);
		csr_read(csr_pkg::MHARTID);
		idle(1);

		// Counters running and then inhibited
		csr_read(csr_pkg::MCYCLE);
		idle(5);
		csr_read(csr_pkg::MCYCLE);
		repeat (3) begin
			@(posedge clk);
			instr_ret <= 1'b1;
			@(posedge clk);
			instr_ret <= 1'b0;
		end
		csr_read(csr_pkg::MINSTRET);
		csr_write(csr_pkg::MCOUNTINHIBIT, 32'h5, csr_pkg::wtype_set);
		csr_read(csr_pkg::MCYCLE);
		@(posedge clk);
		instr_ret <= 1'b1;
		idle(3);
		csr_read(csr_pkg::MCYCLE);
		csr_read(csr_pkg::MINSTRET);
		csr_read(csr_pkg::MCYCLEH);
		csr_write(csr_pkg::MCOUNTINHIBIT, 32'h5, csr_pkg::wtype_clear);

		// Timer interrupt with vectored mtvec
		csr_write(csr_pkg::MTVEC, 32'h0000_0101, csr_pkg::wtype_write);
		csr_write(csr_pkg::MIE, 32'h80, csr_pkg::wtype_set);
		csr_write(csr_pkg::MSTATUS, 32'h8, csr_pkg::wtype_set);
		@(posedge clk);
		wen       <= 1'b0;
		mepc_in   <= 32'h0000_2001;
		irq_timer <= 1'b1;
		wait_trap();
		accept_trap();
		irq_timer <= 1'b0;
		csr_read(csr_pkg::MCAUSE);
		csr_read(csr_pkg::MSTATUS);
		csr_read(csr_pkg::MEPC);

		// ecall and then mret back to mepc
		csr_write(csr_pkg::MSTATUS, 32'h8, csr_pkg::wtype_set);
		raise_except(csr_pkg::except_ecall, 32'h0000_3000);
		wait_trap();
		accept_trap();
		csr_read(csr_pkg::MCAUSE);
		csr_read(csr_pkg::MSTATUS);
		raise_except(csr_pkg::except_mret, 32'h0000_0000);
		wait_trap();
		accept_trap();
		csr_read(csr_pkg::MSTATUS);

		// External lines 2 and 5 enabled and line 1 pending but masked
		csr_write(csr_pkg::MEIE0, 32'h24, csr_pkg::wtype_write);
		@(posedge clk);
		wen <= 1'b0;
		irq <= 8'h26;
		idle(2);
		csr_read(csr_pkg::MEIP0);
		csr_read(csr_pkg::MLEI);
		csr_read(csr_pkg::MIP);
		idle(2);

		$display("checks failed: %0d, timeouts: %0d", check_errors, timeouts);
		if (check_errors == 0 && timeouts == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: bench/csr_unit_checker.sv
`timescale 1ns/1ps

module csr_unit_checker #(
	parameter int NUM_IRQ = 8,
	parameter logic [31:0] MTVEC_INIT = '0
) (
	input  logic                clk,
	input  logic                rst_n,
	input  csr_pkg::csr_addr_t  addr,
	input  logic [31:0]         wdata,
	input  logic                wen, ren,
	input  csr_pkg::csr_wtype_e wtype,
	input  logic [31:0]         rdata,
	input  logic                illegal,
	input  logic [31:0]         trap_addr,
	input  logic                trap_is_irq, trap_enter_vld, trap_enter_rdy,
	input  logic [31:0]         mepc_in,
	input  csr_pkg::except_e    except,
	input  logic                delay_irq_entry,
	input  logic [NUM_IRQ-1:0]  irq,
	input  logic                irq_software, irq_timer, instr_ret,
	output int                  errors
);

	localparam logic [31:0] IRQ_MASK = ~(32'hffff_ffff << NUM_IRQ);

	logic [31:0]        m_mscratch, m_mepc, m_mtvec, m_mcause, m_mie, m_meie0;
	logic               m_sie, m_spie;             // mstatus mie and mpie
	logic [NUM_IRQ-1:0] m_irq;
	logic               m_sw, m_tim, m_inh_cy, m_inh_ir;
	logic [63:0]        m_cycle, m_instret;
	logic [31:0]        m_mip, m_std, m_ext, status_new, inh_new;
	logic [31:0]        exp_rdata, exp_taddr;
	logic               exp_vld, exp_irq, exp_mapped, exp_ro, exp_illegal, exc, is_mret;
	logic               wr_inh, take;
	logic [4:0]         std_n;
	int                 err_cnt = 0;

	assign errors = err_cnt;

	// Write, set or clear on the bits in mask only
	function automatic logic [31:0] combine(input logic [31:0] prev, input logic [31:0] wd,
		input csr_pkg::csr_wtype_e t, input logic [31:0] mask);
		logic [31:0] v;
		if (t == csr_pkg::wtype_set)
			v = prev | wd;
		else if (t == csr_pkg::wtype_clear)
			v = prev & ~wd;
		else
			v = wd;
		return (v & mask) | (prev & ~mask);
	endfunction

	// Index of the lowest one, zero when none
	function automatic logic [4:0] first_set(input logic [31:0] w);
		for (int i = 0; i < 32; i++)
			if (w[i])
				return 5'(i);
		return 5'd0;
	endfunction

	// ------------------------------------------------------------------
	// Expected combinational outputs
	// ------------------------------------------------------------------
	always_comb begin
		m_ext = 32'(m_irq) & m_meie0;
		m_mip = '0;
		m_mip[3] = m_sw;                           // msip
		m_mip[7] = m_tim;                          // mtip
		m_mip[11] = |m_ext;                        // meip summary
		m_std = m_mip & m_mie;
		std_n = first_set(m_std);
		exc = except != csr_pkg::except_none;
		is_mret = except == csr_pkg::except_mret;
		exp_irq = !exc && m_sie && |m_std && !delay_irq_entry;
		exp_vld = exc || exp_irq;
		exp_taddr = is_mret ? m_mepc : {m_mtvec[31:2], 2'b00}
			+ ((exp_irq && m_mtvec[0]) ? 32'(std_n) * 32'd4 : 32'd0);
		take = exp_vld && trap_enter_rdy;
		wr_inh = wen && addr == csr_pkg::MCOUNTINHIBIT;
		status_new = combine({24'd0, m_spie, 3'd0, m_sie, 3'd0}, wdata, wtype, 32'h88);
		inh_new = combine({29'd0, m_inh_ir, 1'b0, m_inh_cy}, wdata, wtype, 32'h5);
		exp_mapped = 1'b1;
		exp_ro = 1'b0;
		exp_rdata = '0;
		case (addr)
			csr_pkg::MISA: begin
				exp_rdata = 32'h4000_0100;         // RV32I
				exp_ro = 1'b1;
			end
			csr_pkg::MHARTID:  exp_ro = 1'b1;
			csr_pkg::MSTATUS:  exp_rdata = 32'h1800 | (32'(m_spie) << 7) | (32'(m_sie) << 3);
			csr_pkg::MTVEC:    exp_rdata = m_mtvec & ~32'h2;
			csr_pkg::MEPC:     exp_rdata = m_mepc;
			csr_pkg::MCAUSE:   exp_rdata = m_mcause & 32'h8000_001f;
			csr_pkg::MIE:      exp_rdata = m_mie;
			csr_pkg::MIP:      exp_rdata = m_mip;
			csr_pkg::MSCRATCH: exp_rdata = m_mscratch;
			csr_pkg::MCOUNTINHIBIT: exp_rdata = {29'd0, m_inh_ir, 1'b0, m_inh_cy};
			csr_pkg::MCYCLE:    exp_rdata = m_cycle[31:0];
			csr_pkg::MCYCLEH:   exp_rdata = m_cycle[63:32];
			csr_pkg::MINSTRET:  exp_rdata = m_instret[31:0];
			csr_pkg::MINSTRETH: exp_rdata = m_instret[63:32];
			csr_pkg::MEIE0:     exp_rdata = m_meie0;
			csr_pkg::MEIP0: begin
				exp_rdata = 32'(m_irq);
				exp_ro = 1'b1;
			end
			csr_pkg::MLEI: begin
				exp_rdata = {27'd0, first_set(m_ext)};
				exp_ro = 1'b1;
			end
			default: exp_mapped = 1'b0;
		endcase
		exp_illegal = ((wen || ren) && !exp_mapped) || (wen && exp_ro);
	end

	// ------------------------------------------------------------------
	// Register model
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_mscratch <= '0;
			m_mepc     <= '0;
			m_mtvec    <= MTVEC_INIT;
			m_mcause   <= '0;
			m_mie      <= '0;
			m_meie0    <= '0;
			m_sie      <= 1'b0;
			m_spie     <= 1'b0;
			m_irq      <= '0;
			m_sw       <= 1'b0;
			m_tim      <= 1'b0;
		end else begin
			m_irq <= irq;                          // One stage on every source
			m_sw  <= irq_software;
			m_tim <= irq_timer;
			if (take && !is_mret) begin
				m_spie   <= m_sie;
				m_sie    <= 1'b0;
				m_mepc   <= mepc_in & ~32'h1;
				m_mcause <= {!exc, 26'd0, exc ? {1'b0, except} : std_n};
			end else if (take) begin
				m_spie <= 1'b1;
				m_sie  <= m_spie;
			end else if (wen) begin
				case (addr)
					csr_pkg::MSTATUS: begin
						m_sie  <= status_new[3];
						m_spie <= status_new[7];
					end
					csr_pkg::MTVEC:    m_mtvec    <= combine(m_mtvec, wdata, wtype, ~32'h2);
					csr_pkg::MEPC:     m_mepc     <= combine(m_mepc, wdata, wtype, ~32'h1);
					csr_pkg::MCAUSE:   m_mcause   <= combine(m_mcause, wdata, wtype, '1);
					csr_pkg::MIE:      m_mie      <= combine(m_mie, wdata, wtype, 32'h888);
					csr_pkg::MSCRATCH: m_mscratch <= combine(m_mscratch, wdata, wtype, '1);
					csr_pkg::MEIE0:    m_meie0    <= combine(m_meie0, wdata, wtype, IRQ_MASK);
					default: ;
				endcase
			end
		end
	end

	// Counters, writes beat the increment
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_cycle   <= '0;
			m_instret <= '0;
			m_inh_cy  <= 1'b0;
			m_inh_ir  <= 1'b0;
		end else begin
			if (wen && addr == csr_pkg::MCYCLE)
				m_cycle[31:0] <= combine(m_cycle[31:0], wdata, wtype, '1);
			else if (wen && addr == csr_pkg::MCYCLEH)
				m_cycle[63:32] <= combine(m_cycle[63:32], wdata, wtype, '1);
			else if (!m_inh_cy && !wr_inh)
				m_cycle <= m_cycle + 64'd1;
			if (wen && addr == csr_pkg::MINSTRET)
				m_instret[31:0] <= combine(m_instret[31:0], wdata, wtype, '1);
			else if (wen && addr == csr_pkg::MINSTRETH)
				m_instret[63:32] <= combine(m_instret[63:32], wdata, wtype, '1);
			else if (instr_ret && !m_inh_ir && !wr_inh)
				m_instret <= m_instret + 64'd1;
			if (wr_inh) begin
				m_inh_cy <= inh_new[0];
				m_inh_ir <= inh_new[2];
			end
		end
	end

	// ------------------------------------------------------------------
	// Checks against the model
	// ------------------------------------------------------------------
	a_rdata: assert property (@(posedge clk) disable iff (!rst_n) ren |-> rdata == exp_rdata)
		else begin
			err_cnt++;
			$display("mismatch at %0t rdata got %h exp %h", $time, $sampled(rdata),
				$sampled(exp_rdata));
		end

	a_illegal: assert property (@(posedge clk) disable iff (!rst_n) illegal == exp_illegal)
		else begin
			err_cnt++;
			$display("mismatch at %0t illegal got %b exp %b", $time, $sampled(illegal),
				$sampled(exp_illegal));
		end

	a_vld: assert property (@(posedge clk) disable iff (!rst_n) trap_enter_vld == exp_vld)
		else begin
			err_cnt++;
			$display("mismatch at %0t trap_enter_vld got %b exp %b", $time,
				$sampled(trap_enter_vld), $sampled(exp_vld));
		end

	a_taddr: assert property (@(posedge clk) disable iff (!rst_n)
		exp_vld |-> trap_addr == exp_taddr)
		else begin
			err_cnt++;
			$display("mismatch at %0t trap_addr got %h exp %h", $time, $sampled(trap_addr),
				$sampled(exp_taddr));
		end

	a_is_irq: assert property (@(posedge clk) disable iff (!rst_n)
		exp_vld |-> trap_is_irq == exp_irq)
		else begin
			err_cnt++;
			$display("mismatch at %0t trap_is_irq got %b exp %b", $time,
				$sampled(trap_is_irq), $sampled(exp_irq));
		end

	// Handler return address is halfword aligned
	a_mepc_even: assert property (@(posedge clk) disable iff (!rst_n)
		(ren && addr == csr_pkg::MEPC) |-> !rdata[0])
		else begin
			err_cnt++;
			$display("mepc read back with bit 0 set at %0t", $time);
		end

endmodule

// File: logic/csr_unit.sv
`timescale 1ns/1ps

module csr_unit #(
	parameter int NUM_IRQ   = 8,            // 1 to 32
	parameter int W_COUNTER = 64,           // 33 to 64
	parameter logic [csr_pkg::XLEN-1:0] MTVEC_INIT = '0
) (
	input  logic                     clk,
	input  logic                     rst_n,
	// CSR access port
	input  csr_pkg::csr_addr_t       addr,
	input  logic [csr_pkg::XLEN-1:0] wdata,
	input  logic                     wen,
	input  csr_pkg::csr_wtype_e      wtype,
	input  logic                     ren,
	output logic [csr_pkg::XLEN-1:0] rdata,
	output logic                     illegal,
	// Trap handshake
	output logic [csr_pkg::XLEN-1:0] trap_addr,
	output logic                     trap_is_irq,
	output logic                     trap_enter_vld,
	input  logic                     trap_enter_rdy,
	input  logic [csr_pkg::XLEN-1:0] mepc_in,
	input  csr_pkg::except_e         except,
	// Interrupt sources, level sensitive
	input  logic                     delay_irq_entry,
	input  logic [NUM_IRQ-1:0]       irq,
	input  logic                     irq_software,
	input  logic                     irq_timer,
	input  logic                     instr_ret
);

	// ------------------------------------------------------------------
	// Internal nets, named as the block ports they join
	// ------------------------------------------------------------------
	logic                     mstatus_mie, mstatus_mpie;
	logic [csr_pkg::XLEN-1:0] mtvec, mepc, mcause, mie, mscratch, meie0;
	logic [csr_pkg::XLEN-1:0] pending_word, meip0;
	logic [4:0]               ext_enabled_num, std_num, cause_code;
	logic                     std_active, cause_irq;
	logic                     trap_take_entry, trap_take_return;
	logic [63:0]              mcycle_full, minstret_full;
	logic                     inhibit_cy, inhibit_ir;

	csr_trap_regs #(.NUM_IRQ(NUM_IRQ), .MTVEC_INIT(MTVEC_INIT)) u_trap_regs (.*);

	csr_counters #(.W_COUNTER(W_COUNTER)) u_counters (.*);

	irq_pending #(.NUM_IRQ(NUM_IRQ)) u_irq_pending (.*);

	trap_request u_trap_request (.*);

	csr_read_decode #(.NUM_IRQ(NUM_IRQ)) u_read_decode (.*);

endmodule

// File: logic/csr_read_decode.sv
`timescale 1ns/1ps

module csr_read_decode #(
	parameter int NUM_IRQ = 8
) (
	input  csr_pkg::csr_addr_t       addr,
	input  logic                     wen,
	input  logic                     ren,
	input  logic                     mstatus_mie,
	input  logic                     mstatus_mpie,
	input  logic [csr_pkg::XLEN-1:0] mtvec,
	input  logic [csr_pkg::XLEN-1:0] mepc,
	input  logic [csr_pkg::XLEN-1:0] mcause,
	input  logic [csr_pkg::XLEN-1:0] mie,
	input  logic [csr_pkg::XLEN-1:0] mscratch,
	input  logic [csr_pkg::XLEN-1:0] meie0,
	input  logic [csr_pkg::XLEN-1:0] pending_word,
	input  logic [csr_pkg::XLEN-1:0] meip0,
	input  logic [4:0]               ext_enabled_num,
	input  logic [63:0]              mcycle_full,
	input  logic [63:0]              minstret_full,
	input  logic                     inhibit_cy,
	input  logic                     inhibit_ir,
	output logic [csr_pkg::XLEN-1:0] rdata,
	output logic                     illegal
);

	localparam logic [csr_pkg::XLEN-1:0] IRQ_MASK = ~({csr_pkg::XLEN{1'b1}} << NUM_IRQ);

	logic decode_match;
	logic read_only;

	always_comb begin
		decode_match = 1'b1;                    // Cleared by the default arm
		read_only    = 1'b0;
		rdata        = '0;
		case (addr)
			csr_pkg::MISA: begin
				rdata     = csr_pkg::MISA_VALUE;
				read_only = 1'b1;
			end
			csr_pkg::MHARTID: read_only = 1'b1; // Single hart, id 0
			csr_pkg::MSTATUS: begin
				rdata[12:11] = 2'b11;             // MPP, machine mode only
				rdata[csr_pkg::MSTATUS_MPIE] = mstatus_mpie;
				rdata[csr_pkg::MSTATUS_MIE]  = mstatus_mie;
			end
			csr_pkg::MTVEC:    rdata = {mtvec[csr_pkg::XLEN-1:2], 1'b0, mtvec[0]};
			csr_pkg::MEPC:     rdata = mepc;
			csr_pkg::MCAUSE: begin
				rdata[csr_pkg::XLEN-1] = mcause[csr_pkg::XLEN-1];
				rdata[4:0] = mcause[4:0];
			end
			csr_pkg::MIE:      rdata = mie;
			csr_pkg::MIP:      rdata = pending_word; // Writes accepted and dropped
			csr_pkg::MSCRATCH: rdata = mscratch;
			csr_pkg::MCOUNTINHIBIT: begin
				rdata[csr_pkg::MCOUNTINHIBIT_CY] = inhibit_cy;
				rdata[csr_pkg::MCOUNTINHIBIT_IR] = inhibit_ir;
			end
			csr_pkg::MCYCLE:    rdata = mcycle_full[31:0];
			csr_pkg::MCYCLEH:   rdata = mcycle_full[63:32];
			csr_pkg::MINSTRET:  rdata = minstret_full[31:0];
			csr_pkg::MINSTRETH: rdata = minstret_full[63:32];
			csr_pkg::MEIE0:     rdata = meie0 & IRQ_MASK;
			csr_pkg::MEIP0: begin
				rdata     = meip0 & IRQ_MASK;
				read_only = 1'b1;
			end
			csr_pkg::MLEI: begin
				rdata[4:0] = ext_enabled_num;
				read_only  = 1'b1;
			end
			default: decode_match = 1'b0;
		endcase
	end

	// Unmapped access, or a write to a constant or status register
	assign illegal = ((wen || ren) && !decode_match) || (wen && read_only);

endmodule

// File: logic/trap_request.sv
`timescale 1ns/1ps

module trap_request (
	input  csr_pkg::except_e         except,
	input  logic                     delay_irq_entry,
	input  logic                     std_active,
	input  logic [4:0]               std_num,
	input  logic [csr_pkg::XLEN-1:0] mtvec,
	input  logic [csr_pkg::XLEN-1:0] mepc,
	input  logic                     trap_enter_rdy,
	output logic                     trap_enter_vld,
	output logic [csr_pkg::XLEN-1:0] trap_addr,
	output logic                     trap_is_irq,
	output logic                     trap_take_entry,
	output logic                     trap_take_return,
	output logic                     cause_irq,
	output logic [4:0]               cause_code
);

	logic                     exc_req;      // Any exception, mret included
	logic                     irq_req;
	logic                     is_mret;
	logic                     accept;
	logic [csr_pkg::XLEN-1:0] vec_off;

	assign exc_req = except != csr_pkg::except_none;
	assign is_mret = except == csr_pkg::except_mret;
	assign irq_req = std_active && !delay_irq_entry; // Core may hold off irq entry

	// ------------------------------------------------------------------
	// Request, exceptions win over interrupts
	// ------------------------------------------------------------------
	assign trap_enter_vld = exc_req || irq_req;
	assign trap_is_irq    = !exc_req && irq_req;
	assign cause_irq      = !exc_req;
	assign cause_code     = exc_req ? {1'b0, except} : std_num;

	// Vectored mode, irq n lands at base + 4n
	always_comb begin
		vec_off = '0;
		if (trap_is_irq && mtvec[0])
			vec_off[6:2] = std_num;
	end

	assign trap_addr = is_mret ? mepc : {mtvec[csr_pkg::XLEN-1:2], 2'b00} + vec_off;

	// Handshake turns into one-cycle strobes for the register block
	assign accept           = trap_enter_vld && trap_enter_rdy;
	assign trap_take_entry  = accept && !is_mret;
	assign trap_take_return = accept && is_mret;

	// Handler entry points are always word aligned
	always_comb begin
		if (trap_enter_vld && !is_mret)
			assert (trap_addr[1:0] == 2'b00)
			else $error("trap_addr %h not word aligned", trap_addr);
	end

endmodule

// File: logic/irq_pending.sv
`timescale 1ns/1ps

module irq_pending #(
	parameter int NUM_IRQ = 8
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [NUM_IRQ-1:0]       irq,
	input  logic                     irq_software,
	input  logic                     irq_timer,
	input  logic [csr_pkg::XLEN-1:0] meie0,
	input  logic [csr_pkg::XLEN-1:0] mie,
	input  logic                     mstatus_mie,
	output logic [csr_pkg::XLEN-1:0] pending_word,
	output logic [csr_pkg::XLEN-1:0] meip0,
	output logic [4:0]               ext_enabled_num,
	output logic                     std_active,
	output logic [4:0]               std_num
);

	logic [NUM_IRQ-1:0]       irq_r;
	logic                     irq_software_r, irq_timer_r;
	logic [csr_pkg::XLEN-1:0] ext_req;      // Enabled external lines
	logic [csr_pkg::XLEN-1:0] std_req;      // Enabled mip bits

	// Level inputs, one register stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_r          <= '0;
			irq_software_r <= 1'b0;
			irq_timer_r    <= 1'b0;
		end else begin
			irq_r          <= irq;
			irq_software_r <= irq_software;
			irq_timer_r    <= irq_timer;
		end
	end

	always_comb begin
		meip0 = '0;
		meip0[NUM_IRQ-1:0] = irq_r;
		pending_word = '0;
		pending_word[csr_pkg::MIP_MSIP] = irq_software_r;
		pending_word[csr_pkg::MIP_MTIP] = irq_timer_r;
		pending_word[csr_pkg::MIP_MEIP] = |ext_req;    // Summary of all external lines
	end

	assign ext_req = meie0 & meip0;
	assign std_req = pending_word & mie;

	assign ext_enabled_num = csr_pkg::lowest_set(ext_req);
	assign std_active      = mstatus_mie && |std_req;
	assign std_num         = csr_pkg::lowest_set(std_req); // msip before mtip before meip

endmodule

// File: logic/csr_counters.sv
`timescale 1ns/1ps

module csr_counters #(
	parameter int W_COUNTER = 64
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  csr_pkg::csr_addr_t       addr,
	input  logic [csr_pkg::XLEN-1:0] wdata,
	input  logic                     wen,
	input  csr_pkg::csr_wtype_e      wtype,
	input  logic                     instr_ret,
	output logic [63:0]              mcycle_full,
	output logic [63:0]              minstret_full,
	output logic                     inhibit_cy,
	output logic                     inhibit_ir
);

	// Bits at and above W_COUNTER hold their written value
	localparam logic [63:0] CTR_MASK = ~({64{1'b1}} << W_COUNTER);
	localparam logic [csr_pkg::XLEN-1:0] INH_MASK =
		(1 << csr_pkg::MCOUNTINHIBIT_CY) | (1 << csr_pkg::MCOUNTINHIBIT_IR);

	logic                     wr_cy_lo, wr_cy_hi, wr_ir_lo, wr_ir_hi, wr_inh;
	logic [csr_pkg::XLEN-1:0] ctr_prev;
	logic [csr_pkg::XLEN-1:0] ctr_new;
	logic [csr_pkg::XLEN-1:0] inh_view;
	logic [csr_pkg::XLEN-1:0] inh_new;

	function automatic logic [63:0] ctr_step(input logic [63:0] v);
		return ((v + 64'd1) & CTR_MASK) | (v & ~CTR_MASK);
	endfunction

	assign wr_cy_lo = wen && addr == csr_pkg::MCYCLE;
	assign wr_cy_hi = wen && addr == csr_pkg::MCYCLEH;
	assign wr_ir_lo = wen && addr == csr_pkg::MINSTRET;
	assign wr_ir_hi = wen && addr == csr_pkg::MINSTRETH;
	assign wr_inh   = wen && addr == csr_pkg::MCOUNTINHIBIT;

	// One shared write path, the address picks the half
	always_comb begin
		case (addr)
			csr_pkg::MCYCLE:   ctr_prev = mcycle_full[31:0];
			csr_pkg::MCYCLEH:  ctr_prev = mcycle_full[63:32];
			csr_pkg::MINSTRET: ctr_prev = minstret_full[31:0];
			default:           ctr_prev = minstret_full[63:32];
		endcase
		inh_view = '0;
		inh_view[csr_pkg::MCOUNTINHIBIT_CY] = inhibit_cy;
		inh_view[csr_pkg::MCOUNTINHIBIT_IR] = inhibit_ir;
	end

	assign ctr_new = csr_pkg::csr_update(ctr_prev, wdata, wtype, '1);
	assign inh_new = csr_pkg::csr_update(inh_view, wdata, wtype, INH_MASK);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mcycle_full   <= '0;
			minstret_full <= '0;
			inhibit_cy    <= 1'b0;
			inhibit_ir    <= 1'b0;
		end else begin
			if (wr_cy_lo)      mcycle_full[31:0]  <= ctr_new;
			else if (wr_cy_hi) mcycle_full[63:32] <= ctr_new;
			else if (!inhibit_cy && !wr_inh) mcycle_full <= ctr_step(mcycle_full);
			if (wr_ir_lo)      minstret_full[31:0]  <= ctr_new;
			else if (wr_ir_hi) minstret_full[63:32] <= ctr_new;
			else if (instr_ret && !inhibit_ir && !wr_inh) minstret_full <= ctr_step(minstret_full);
			if (wr_inh) begin
				inhibit_cy <= inh_new[csr_pkg::MCOUNTINHIBIT_CY];
				inhibit_ir <= inh_new[csr_pkg::MCOUNTINHIBIT_IR];
			end
		end
	end

	a_cycle_step: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(wr_cy_lo || wr_cy_hi) |->
		(mcycle_full == $past(mcycle_full) || mcycle_full == ctr_step($past(mcycle_full))));

endmodule

// File: logic/csr_trap_regs.sv
`timescale 1ns/1ps

module csr_trap_regs #(
	parameter int NUM_IRQ = 8,
	parameter logic [csr_pkg::XLEN-1:0] MTVEC_INIT = '0
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  csr_pkg::csr_addr_t       addr,
	input  logic [csr_pkg::XLEN-1:0] wdata,
	input  logic                     wen,
	input  csr_pkg::csr_wtype_e      wtype,
	input  logic                     trap_take_entry,
	input  logic                     trap_take_return,
	input  logic [csr_pkg::XLEN-1:0] mepc_in,
	input  logic                     cause_irq,
	input  logic [4:0]               cause_code,
	output logic                     mstatus_mie,
	output logic                     mstatus_mpie,
	output logic [csr_pkg::XLEN-1:0] mtvec,
	output logic [csr_pkg::XLEN-1:0] mepc,
	output logic [csr_pkg::XLEN-1:0] mcause,
	output logic [csr_pkg::XLEN-1:0] mie,
	output logic [csr_pkg::XLEN-1:0] mscratch,
	output logic [csr_pkg::XLEN-1:0] meie0
);

	// Writable bits per register
	localparam logic [csr_pkg::XLEN-1:0] MSTATUS_MASK =
		(1 << csr_pkg::MSTATUS_MIE) | (1 << csr_pkg::MSTATUS_MPIE);
	localparam logic [csr_pkg::XLEN-1:0] MIE_MASK =
		(1 << csr_pkg::MIP_MSIP) | (1 << csr_pkg::MIP_MTIP) | (1 << csr_pkg::MIP_MEIP);
	localparam logic [csr_pkg::XLEN-1:0] MTVEC_MASK  = ~32'h0000_0002; // Bit 1 reserved
	localparam logic [csr_pkg::XLEN-1:0] MEPC_MASK   = ~32'h0000_0001; // Halfword aligned
	localparam logic [csr_pkg::XLEN-1:0] MCAUSE_MASK = 32'h8000_001f;  // Irq flag and code
	localparam logic [csr_pkg::XLEN-1:0] MEIE0_MASK  = ~({csr_pkg::XLEN{1'b1}} << NUM_IRQ);

	logic [csr_pkg::XLEN-1:0] mstatus_view;
	logic [csr_pkg::XLEN-1:0] mstatus_wr;
	logic [csr_pkg::XLEN-1:0] cause_word;

	// mstatus as a word so it can go through the common write path
	always_comb begin
		mstatus_view = '0;
		mstatus_view[csr_pkg::MSTATUS_MIE]  = mstatus_mie;
		mstatus_view[csr_pkg::MSTATUS_MPIE] = mstatus_mpie;
		cause_word = '0;
		cause_word[csr_pkg::XLEN-1] = cause_irq; // Interrupt flag in the sign bit
		cause_word[4:0] = cause_code;
	end

	assign mstatus_wr = csr_pkg::csr_update(mstatus_view, wdata, wtype, MSTATUS_MASK);

	// ------------------------------------------------------------------
	// Register update, trap pulses first
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
			mtvec        <= MTVEC_INIT;
			mepc         <= '0;
			mcause       <= '0;
			mie          <= '0;
			mscratch     <= '0;
			meie0        <= '0;
		end else if (trap_take_entry) begin
			mstatus_mpie <= mstatus_mie;        // Push enable stack
			mstatus_mie  <= 1'b0;
			mepc         <= mepc_in & MEPC_MASK;
			mcause       <= cause_word;
		end else if (trap_take_return) begin
			mstatus_mpie <= 1'b1;               // Pop enable stack
			mstatus_mie  <= mstatus_mpie;
		end else if (wen) begin
			case (addr)
				csr_pkg::MSTATUS: begin
					mstatus_mie  <= mstatus_wr[csr_pkg::MSTATUS_MIE];
					mstatus_mpie <= mstatus_wr[csr_pkg::MSTATUS_MPIE];
				end
				csr_pkg::MTVEC:    mtvec    <= csr_pkg::csr_update(mtvec, wdata, wtype, MTVEC_MASK);
				csr_pkg::MEPC:     mepc     <= csr_pkg::csr_update(mepc, wdata, wtype, MEPC_MASK);
				csr_pkg::MCAUSE:   mcause   <= csr_pkg::csr_update(mcause, wdata, wtype, MCAUSE_MASK);
				csr_pkg::MIE:      mie      <= csr_pkg::csr_update(mie, wdata, wtype, MIE_MASK);
				csr_pkg::MSCRATCH: mscratch <= csr_pkg::csr_update(mscratch, wdata, wtype, '1);
				csr_pkg::MEIE0:    meie0    <= csr_pkg::csr_update(meie0, wdata, wtype, MEIE0_MASK);
				default: ;                      // Other CSRs live elsewhere
			endcase
		end
	end

	// Entry and return come from one accepted request, never both
	a_one_trap_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		!(trap_take_entry && trap_take_return));

endmodule

// File: logic/csr_pkg.sv
package csr_pkg;

	// ------------------------------------------------------------------
	// Basic types
	// ------------------------------------------------------------------
	localparam int XLEN = 32;                  // RV32 only

	typedef logic [11:0] csr_addr_t;

	// Machine information, read only
	localparam csr_addr_t MISA          = 12'h301;
	localparam csr_addr_t MHARTID       = 12'hf14;
	// Trap setup and handling
	localparam csr_addr_t MSTATUS       = 12'h300;
	localparam csr_addr_t MIE           = 12'h304;
	localparam csr_addr_t MTVEC         = 12'h305;
	localparam csr_addr_t MSCRATCH      = 12'h340;
	localparam csr_addr_t MEPC          = 12'h341;
	localparam csr_addr_t MCAUSE        = 12'h342;
	localparam csr_addr_t MIP           = 12'h344;
	// Counters
	localparam csr_addr_t MCOUNTINHIBIT = 12'h320;
	localparam csr_addr_t MCYCLE        = 12'hb00;
	localparam csr_addr_t MINSTRET      = 12'hb02;
	localparam csr_addr_t MCYCLEH       = 12'hb80;
	localparam csr_addr_t MINSTRETH     = 12'hb82;
	// Custom external interrupt block
	localparam csr_addr_t MEIE0         = 12'hbe0; // Enable per external irq
	localparam csr_addr_t MEIP0         = 12'hfe0; // Registered irq lines, read only
	localparam csr_addr_t MLEI          = 12'hfe4; // Lowest enabled pending, read only

	// Field positions
	localparam int MSTATUS_MIE      = 3;
	localparam int MSTATUS_MPIE     = 7;
	localparam int MIP_MSIP         = 3;
	localparam int MIP_MTIP         = 7;
	localparam int MIP_MEIP         = 11;
	localparam int MCOUNTINHIBIT_CY = 0;
	localparam int MCOUNTINHIBIT_IR = 2;

	localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100; // MXL 1, base I

	typedef enum logic [1:0] {
		wtype_write = 2'd0,
		wtype_set   = 2'd1,
		wtype_clear = 2'd2
	} csr_wtype_e;

	// Values are the mcause exception codes
	typedef enum logic [3:0] {
		except_instr_misalign = 4'd0,
		except_illegal        = 4'd2,
		except_ebreak         = 4'd3,
		except_mret           = 4'd10, // Not a real cause, return request
		except_ecall          = 4'd11,
		except_none           = 4'd15
	} except_e;

	// Write, set or clear, restricted to the writable bits in mask
	function automatic logic [XLEN-1:0] csr_update(input logic [XLEN-1:0] prev,
		input logic [XLEN-1:0] wdata, input csr_wtype_e wtype, input logic [XLEN-1:0] mask);
		logic [XLEN-1:0] comb;
		case (wtype)
			wtype_set:   comb = prev | wdata;
			wtype_clear: comb = prev & ~wdata;
			default:     comb = wdata;
		endcase
		return (comb & mask) | (prev & ~mask);
	endfunction

	// Priority encoder, bit 0 highest
	function automatic logic [4:0] lowest_set(input logic [31:0] word);
		logic [4:0] idx;
		idx = 5'd0;
		for (int i = 31; i >= 0; i--)
			if (word[i]) idx = 5'(i);     // Last hit is the lowest
		return idx;
	endfunction

endpackage
